//--- dv/apb_delay_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "apb_delay_params.svh"

module apb_delay_tb import apb_delay_pkg::*; ();

    logic                   clock;
    logic                   reset;
    logic                   cmd_start;
    apb_op_t                cmd_op;
    logic [`APB_ADDR_W-1:0] cmd_addr;
    logic [`APB_DATA_W-1:0] cmd_wdata;
    logic [`APB_STRB_W-1:0] cmd_strb;
    logic [`APB_PROT_W-1:0] cmd_prot;
    logic                   delay_enable;
    wire                    busy;
    wire                    done;
    wire  [`APB_DATA_W-1:0] rdata;
    wire                    slverr;

    logic [`APB_DATA_W-1:0] shadow_mem [`MEM_WORDS];
    logic [`APB_ADDR_W-1:0] used_addr [6];
    logic [15:0]            lfsr_state;
    int                     edge_count  = 0;
    int                     launch_edge = 0;
    int                     done_count  = 0;
    int                     start_count = 0;

    logic                   exp_is_read;
    logic [`APB_DATA_W-1:0] exp_rdata;
    logic                   exp_err;
    int                     exp_latency;
    int                     exp_hold;
    logic [`APB_DATA_W-1:0] last_rdata;
    logic                   last_err;
    int                     last_latency;

    apb_delay_top UUT (
        .clock        (clock),
        .reset        (reset),
        .cmd_start    (cmd_start),
        .cmd_op       (cmd_op),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .cmd_strb     (cmd_strb),
        .cmd_prot     (cmd_prot),
        .delay_enable (delay_enable),
        .busy         (busy),
        .done         (done),
        .rdata        (rdata),
        .slverr       (slverr)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // ==============================
    // Random source and reference
    // ==============================
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] result;
        logic        fb;
        result = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};  // x^16+x^14+x^13+x^11+1.
            result     = {result[30:0], fb};
        end
        return result;
    endfunction

    function automatic logic [`APB_ADDR_W-1:0] rand_word_addr();
        int idx;
        idx = `PROT_WORDS + int'(take_bits(6) % (`MEM_WORDS - `PROT_WORDS));
        return `APB_ADDR_W'(idx) << 2;
    endfunction

    function automatic void model_access(input apb_op_t op,
                                         input logic [`APB_ADDR_W-1:0] addr,
                                         input logic [`APB_DATA_W-1:0] wdata,
                                         input logic [`APB_STRB_W-1:0] strb,
                                         input logic [`APB_PROT_W-1:0] prot,
                                         output logic [`APB_DATA_W-1:0] m_rdata,
                                         output logic m_err,
                                         output int m_wait,
                                         output int m_hold);
        logic [`APB_ADDR_W-3:0] idx;
        logic                   fault;
        idx     = addr[`APB_ADDR_W-1:2];
        fault   = (idx >= `MEM_WORDS) || (prot[1] && (idx < `PROT_WORDS));
        m_wait  = int'(idx % 8);
        m_hold  = ((m_wait * `DELAY_RATIO) >> `DELAY_FRAC_BITS) - m_wait;
        m_rdata = '0;
        m_err   = fault;
        if (!fault && (op == OP_WRITE)) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (strb[b]) begin
                    shadow_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (!fault) begin
            m_rdata = shadow_mem[idx];
        end
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic fail_run();
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first failure.");
    endtask

    task automatic check_data(input string name, input logic [`APB_DATA_W-1:0] expected,
                              input logic [`APB_DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_err(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, expected, actual);
            fail_run();
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            fail_run();
        end
    endtask

    // Latency count and result compare, on the edge after done.
    always @(posedge clock) begin
        if (reset && cmd_start && !busy) begin
            launch_edge = edge_count;
        end
        if (done) begin
            last_latency = edge_count - launch_edge;
            last_rdata   = rdata;
            last_err     = slverr;
            if (exp_is_read) begin
                check_data("rdata", exp_rdata, rdata);
            end
            check_err("slverr", exp_err, slverr);
            check_latency("latency", exp_latency, last_latency);
            done_count++;
        end
        edge_count++;
    end

    // ==============================
    // Command sequencing
    // ==============================
    task automatic issue_cmd(input apb_op_t op, input logic [`APB_ADDR_W-1:0] addr,
                             input logic [`APB_DATA_W-1:0] wdata,
                             input logic [`APB_STRB_W-1:0] strb,
                             input logic [`APB_PROT_W-1:0] prot);
        logic [`APB_DATA_W-1:0] m_rdata;
        logic                   m_err;
        int                     m_wait;
        int                     m_hold;
        model_access(op, addr, wdata, strb, prot, m_rdata, m_err, m_wait, m_hold);
        exp_is_read = (op == OP_READ);
        exp_rdata   = m_rdata;
        exp_err     = m_err;
        exp_hold    = m_hold;
        exp_latency = m_wait + 3 + (delay_enable ? m_hold + 1 : 0);
        @(negedge clock);
        cmd_op      = op;
        cmd_addr    = addr;
        cmd_wdata   = wdata;
        cmd_strb    = strb;
        cmd_prot    = prot;
        start_count = done_count;
        cmd_start   = 1'b1;
        @(negedge clock);
        cmd_start   = 1'b0;
    endtask

    task automatic wait_done(input string what, input logic [`APB_ADDR_W-1:0] addr);
        for (int i = 0; (i < 64) && (done_count == start_count); i++) begin
            @(negedge clock);
        end
        if (done_count == start_count) begin
            $display("Timeout: %s at address %h never completed.", what, addr);
            fail_run();
        end
    endtask

    task automatic run_cmd(input apb_op_t op, input logic [`APB_ADDR_W-1:0] addr,
                           input logic [`APB_DATA_W-1:0] wdata,
                           input logic [`APB_STRB_W-1:0] strb,
                           input logic [`APB_PROT_W-1:0] prot);
        issue_cmd(op, addr, wdata, strb, prot);
        wait_done((op == OP_WRITE) ? "write" : "read", addr);
    endtask

    // Same read direct and delayed.
    task automatic compare_delay(input logic [`APB_ADDR_W-1:0] addr,
                                 input logic [`APB_PROT_W-1:0] prot);
        logic [`APB_DATA_W-1:0] base_rdata;
        logic                   base_err;
        int                     base_latency;
        int                     hold;
        delay_enable = 1'b0;
        run_cmd(OP_READ, addr, '0, 4'hF, prot);
        base_rdata   = last_rdata;
        base_err     = last_err;
        base_latency = last_latency;
        hold         = exp_hold;
        delay_enable = 1'b1;
        run_cmd(OP_READ, addr, '0, 4'hF, prot);
        check_data("delayed rdata", base_rdata, last_rdata);
        check_err("delayed slverr", base_err, last_err);
        check_latency("latency increase", hold + 1, last_latency - base_latency);
        delay_enable = 1'b0;
    endtask

    task automatic busy_start_check();
        logic [`APB_ADDR_W-1:0] read_addr;
        logic [`APB_ADDR_W-1:0] skip_addr;
        int                     count_before;
        read_addr    = `APB_ADDR_W'(8 * (1 + take_bits(3) % 7) + 7) << 2;  // W of 7.
        skip_addr    = `APB_ADDR_W'(8 * (1 + take_bits(3) % 7) + take_bits(3) % 7) << 2;
        count_before = done_count;
        issue_cmd(OP_READ, read_addr, '0, 4'hF, 3'b000);
        check_err("busy", 1'b1, busy);
        cmd_op    = OP_WRITE;
        cmd_addr  = skip_addr;
        cmd_wdata = take_bits(32);
        cmd_strb  = 4'hF;
        cmd_start = 1'b1;
        @(negedge clock);
        cmd_start = 1'b0;
        wait_done("read with a start while busy", read_addr);
        repeat (20) @(negedge clock);
        if (done_count != count_before + 1) begin
            $display("A start pulse issued while busy produced an extra done pulse.");
            fail_run();
        end
        run_cmd(OP_READ, skip_addr, '0, 4'hF, 3'b000);  // Must be unchanged.
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        logic [`APB_ADDR_W-1:0] err_addr;
        logic [`APB_ADDR_W-1:0] prot_addr;
        logic [`APB_STRB_W-1:0] strb;
        reset        = 1'b0;
        cmd_start    = 1'b0;
        cmd_op       = OP_READ;
        cmd_addr     = '0;
        cmd_wdata    = '0;
        cmd_strb     = '0;
        cmd_prot     = '0;
        delay_enable = 1'b0;
        exp_is_read  = 1'b0;
        exp_rdata    = '0;
        exp_err      = 1'b0;
        exp_latency  = 0;
        exp_hold     = 0;
        lfsr_state   = 16'd63994;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            shadow_mem[i] = '0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;

        check_err("busy", 1'b0, busy);
        check_err("done", 1'b0, done);
        for (int i = 0; i < 4; i++) begin
            run_cmd(OP_READ, rand_word_addr(), '0, 4'hF, 3'(take_bits(3)));
        end

        for (int i = 0; i < 6; i++) begin
            used_addr[i] = rand_word_addr();
            run_cmd(OP_WRITE, used_addr[i], take_bits(32), 4'hF, 3'(take_bits(3)));
        end
        for (int i = 0; i < 6; i++) begin
            run_cmd(OP_READ, used_addr[i], '0, 4'hF, 3'(take_bits(3)));
        end

        for (int i = 0; i < 6; i++) begin
            strb = 4'(take_bits(4));
            if (strb == 4'hF) begin
                strb = 4'h6;
            end
            run_cmd(OP_WRITE, used_addr[i], take_bits(32), strb, 3'(take_bits(3)));
        end
        for (int i = 0; i < 6; i++) begin
            run_cmd(OP_READ, used_addr[i], '0, 4'hF, 3'(take_bits(3)));
        end

        err_addr  = (`APB_ADDR_W'(`MEM_WORDS) + take_bits(8)) << 2;  // Beyond the memory.
        prot_addr = `APB_ADDR_W'(take_bits(3)) << 2;
        run_cmd(OP_WRITE, err_addr, take_bits(32), 4'hF, 3'b000);
        run_cmd(OP_READ, err_addr, '0, 4'hF, 3'b000);
        run_cmd(OP_WRITE, prot_addr, take_bits(32), 4'hF, 3'b000);
        run_cmd(OP_WRITE, prot_addr, take_bits(32), 4'hF, 3'b010);
        run_cmd(OP_READ, prot_addr, '0, 4'hF, 3'b010);
        run_cmd(OP_READ, prot_addr, '0, 4'hF, 3'b000);

        for (int w = 0; w < 8; w++) begin
            compare_delay(`APB_ADDR_W'(8 * (1 + take_bits(3) % 7) + w) << 2, 3'(take_bits(3)));
        end
        compare_delay(err_addr, 3'b000);
        compare_delay(prot_addr, 3'b010);
        compare_delay(prot_addr, 3'b000);

        delay_enable = 1'b1;
        run_cmd(OP_WRITE, used_addr[0], take_bits(32), 4'(take_bits(4)), 3'b000);
        run_cmd(OP_READ, used_addr[0], '0, 4'hF, 3'b000);
        delay_enable = 1'b0;

        busy_start_check();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/apb_delay_params.svh
`ifndef APB_DELAY_PARAMS_SVH
`define APB_DELAY_PARAMS_SVH

// ==============================
// APB bus
// ==============================
`define APB_ADDR_W      32
`define APB_DATA_W      32
`define APB_STRB_W      4
`define APB_PROT_W      3

// ==============================
// Delay ratio, fixed point
// ==============================
`define DELAY_FRAC_BITS 10
`define DELAY_RATIO     2048  // 2.0 scaled by 1024.
`define DELAY_CNT_W     24

// ==============================
// Memory slave
// ==============================
`define MEM_WORDS       64
`define PROT_WORDS      8     // Secure-only low words.
`define MAX_WAIT        7

`endif

//--- hdl/apb_delay_pkg.sv
`default_nettype none

package apb_delay_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } apb_op_t;

    typedef enum logic [1:0] {
        REQ_IDLE   = 2'd0,
        REQ_SETUP  = 2'd1,
        REQ_ACCESS = 2'd2
    } req_state_t;

    typedef enum logic [1:0] {
        DLY_IDLE    = 2'd0,
        DLY_ACTIVE  = 2'd1,  // Slave access in progress.
        DLY_HOLD    = 2'd2,  // Response held back.
        DLY_RELEASE = 2'd3
    } dly_state_t;

    typedef enum logic [1:0] {
        MEM_IDLE = 2'd0,
        MEM_WAIT = 2'd1
    } mem_state_t;

endpackage

`default_nettype wire

//--- hdl/apb_delay_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "apb_delay_params.svh"

module apb_delay_top import apb_delay_pkg::*; (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     cmd_start,
    input  wire apb_op_t            cmd_op,
    input  wire  [`APB_ADDR_W-1:0]  cmd_addr,
    input  wire  [`APB_DATA_W-1:0]  cmd_wdata,
    input  wire  [`APB_STRB_W-1:0]  cmd_strb,
    input  wire  [`APB_PROT_W-1:0]  cmd_prot,
    input  wire                     delay_enable,
    output logic                    busy,
    output logic                    done,
    output logic [`APB_DATA_W-1:0]  rdata,
    output logic                    slverr
);

    // ==============================
    // Master side of the delayer
    // ==============================
    wire [`APB_ADDR_W-1:0] m_paddr;
    wire                   m_psel;
    wire                   m_penable;
    wire [`APB_PROT_W-1:0] m_pprot;
    wire                   m_pwrite;
    wire [`APB_DATA_W-1:0] m_pwdata;
    wire [`APB_STRB_W-1:0] m_pstrb;
    wire                   m_pready;
    wire [`APB_DATA_W-1:0] m_prdata;
    wire                   m_pslverr;

    // ==============================
    // Slave side of the delayer
    // ==============================
    wire [`APB_ADDR_W-1:0] s_paddr;
    wire                   s_psel;
    wire                   s_penable;
    wire [`APB_PROT_W-1:0] s_pprot;
    wire                   s_pwrite;
    wire [`APB_DATA_W-1:0] s_pwdata;
    wire [`APB_STRB_W-1:0] s_pstrb;
    wire                   s_pready;
    wire [`APB_DATA_W-1:0] s_prdata;
    wire                   s_pslverr;

    apb_requester u_requester (
        .clock     (clock),
        .reset     (reset),
        .cmd_start (cmd_start),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .cmd_strb  (cmd_strb),
        .cmd_prot  (cmd_prot),
        .busy      (busy),
        .done      (done),
        .rdata     (rdata),
        .slverr    (slverr),
        .paddr     (m_paddr),
        .psel      (m_psel),
        .penable   (m_penable),
        .pprot     (m_pprot),
        .pwrite    (m_pwrite),
        .pwdata    (m_pwdata),
        .pstrb     (m_pstrb),
        .pready    (m_pready),
        .prdata    (m_prdata),
        .pslverr   (m_pslverr)
    );

    apb_delayer u_delayer (
        .clock        (clock),
        .reset        (reset),
        .delay_enable (delay_enable),
        .in_paddr     (m_paddr),
        .in_psel      (m_psel),
        .in_penable   (m_penable),
        .in_pprot     (m_pprot),
        .in_pwrite    (m_pwrite),
        .in_pwdata    (m_pwdata),
        .in_pstrb     (m_pstrb),
        .in_pready    (m_pready),
        .in_prdata    (m_prdata),
        .in_pslverr   (m_pslverr),
        .out_paddr    (s_paddr),
        .out_psel     (s_psel),
        .out_penable  (s_penable),
        .out_pprot    (s_pprot),
        .out_pwrite   (s_pwrite),
        .out_pwdata   (s_pwdata),
        .out_pstrb    (s_pstrb),
        .out_pready   (s_pready),
        .out_prdata   (s_prdata),
        .out_pslverr  (s_pslverr)
    );

    apb_wait_memory u_memory (
        .clock   (clock),
        .reset   (reset),
        .paddr   (s_paddr),
        .psel    (s_psel),
        .penable (s_penable),
        .pprot   (s_pprot),
        .pwrite  (s_pwrite),
        .pwdata  (s_pwdata),
        .pstrb   (s_pstrb),
        .pready  (s_pready),
        .prdata  (s_prdata),
        .pslverr (s_pslverr)
    );

endmodule

`default_nettype wire

//--- hdl/apb_delayer.sv
`timescale 1ns/1ns
`default_nettype none
`include "apb_delay_params.svh"

module apb_delayer import apb_delay_pkg::*; (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     delay_enable,

    input  wire  [`APB_ADDR_W-1:0]  in_paddr,
    input  wire                     in_psel,
    input  wire                     in_penable,
    input  wire  [`APB_PROT_W-1:0]  in_pprot,
    input  wire                     in_pwrite,
    input  wire  [`APB_DATA_W-1:0]  in_pwdata,
    input  wire  [`APB_STRB_W-1:0]  in_pstrb,
    output logic                    in_pready,
    output logic [`APB_DATA_W-1:0]  in_prdata,
    output logic                    in_pslverr,

    output logic [`APB_ADDR_W-1:0]  out_paddr,
    output logic                    out_psel,
    output logic                    out_penable,
    output logic [`APB_PROT_W-1:0]  out_pprot,
    output logic                    out_pwrite,
    output logic [`APB_DATA_W-1:0]  out_pwdata,
    output logic [`APB_STRB_W-1:0]  out_pstrb,
    input  wire                     out_pready,
    input  wire  [`APB_DATA_W-1:0]  out_prdata,
    input  wire                     out_pslverr
);

    dly_state_t              state;
    logic [`DELAY_CNT_W-1:0] wait_cnt;   // Slave wait cycles seen.
    logic [`DELAY_CNT_W-1:0] scaled;     // Wait cycles times ratio.
    logic [`DELAY_CNT_W-1:0] hold_cnt;
    logic [`DELAY_CNT_W-1:0] hold_calc;
    logic [`APB_DATA_W-1:0]  cap_rdata;
    logic                    cap_slverr;
    logic                    blocked;
    logic                    slave_access;

    // Slave sees nothing while the response is held back.
    assign blocked      = delay_enable && ((state == DLY_HOLD) || (state == DLY_RELEASE));
    assign out_paddr    = in_paddr;
    assign out_psel     = in_psel && !blocked;
    assign out_penable  = in_penable && !blocked;
    assign out_pprot    = in_pprot;
    assign out_pwrite   = in_pwrite;
    assign out_pwdata   = in_pwdata;
    assign out_pstrb    = in_pstrb;
    assign slave_access = out_psel && out_penable;
    assign hold_calc    = (scaled >> `DELAY_FRAC_BITS) - wait_cnt;  // floor(W*r) - W.

    always_comb begin
        if (delay_enable) begin
            in_pready  = (state == DLY_RELEASE);
            in_prdata  = (state == DLY_RELEASE) ? cap_rdata : '0;
            in_pslverr = (state == DLY_RELEASE) && cap_slverr;
        end else begin
            in_pready  = out_pready;
            in_prdata  = out_prdata;
            in_pslverr = out_pslverr;
        end
    end

    // ==============================
    // Wait measurement and hold
    // ==============================
    always_ff @(posedge clock) begin
        if (!reset) begin
            state    <= DLY_IDLE;
            wait_cnt <= '0;
            scaled   <= '0;
            hold_cnt <= '0;
        end else begin
            case (state)
                DLY_IDLE: begin
                    if (delay_enable && in_psel && !in_penable) begin  // Setup phase.
                        state    <= DLY_ACTIVE;
                        wait_cnt <= '0;
                        scaled   <= '0;
                    end
                end
                DLY_ACTIVE: begin
                    if (slave_access && out_pready) begin
                        hold_cnt <= hold_calc;
                        state    <= (hold_calc == '0) ? DLY_RELEASE : DLY_HOLD;
                    end else if (slave_access) begin
                        wait_cnt <= wait_cnt + 1'b1;
                        scaled   <= scaled + `DELAY_CNT_W'(`DELAY_RATIO);
                    end
                end
                DLY_HOLD: begin
                    hold_cnt <= hold_cnt - 1'b1;
                    if (hold_cnt == `DELAY_CNT_W'(1)) begin
                        state <= DLY_RELEASE;
                    end
                end
                DLY_RELEASE: state <= DLY_IDLE;  // One-cycle pready.
                default:     state <= DLY_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if ((state == DLY_ACTIVE) && slave_access && out_pready) begin
            cap_rdata  <= out_prdata;
            cap_slverr <= out_pslverr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/apb_requester.sv
`timescale 1ns/1ns
`default_nettype none
`include "apb_delay_params.svh"

module apb_requester import apb_delay_pkg::*; (
    input  wire                     clock,
    input  wire                     reset,

    input  wire                     cmd_start,
    input  wire apb_op_t            cmd_op,
    input  wire [`APB_ADDR_W-1:0]   cmd_addr,
    input  wire [`APB_DATA_W-1:0]   cmd_wdata,
    input  wire [`APB_STRB_W-1:0]   cmd_strb,
    input  wire [`APB_PROT_W-1:0]   cmd_prot,
    output logic                    busy,
    output logic                    done,
    output logic [`APB_DATA_W-1:0]  rdata,
    output logic                    slverr,

    output logic [`APB_ADDR_W-1:0]  paddr,
    output logic                    psel,
    output logic                    penable,
    output logic [`APB_PROT_W-1:0]  pprot,
    output logic                    pwrite,
    output logic [`APB_DATA_W-1:0]  pwdata,
    output logic [`APB_STRB_W-1:0]  pstrb,
    input  wire                     pready,
    input  wire  [`APB_DATA_W-1:0]  prdata,
    input  wire                     pslverr
);

    req_state_t state;
    logic       accept;

    assign accept  = (state == REQ_IDLE) && cmd_start;  // Starts while busy are dropped.
    assign busy    = (state != REQ_IDLE);
    assign psel    = (state != REQ_IDLE);
    assign penable = (state == REQ_ACCESS);

    // ==============================
    // Transfer sequencing
    // ==============================
    always_ff @(posedge clock) begin
        if (!reset) begin
            state  <= REQ_IDLE;
            done   <= 1'b0;
            rdata  <= '0;
            slverr <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                REQ_IDLE: begin
                    if (accept) begin
                        state <= REQ_SETUP;
                    end
                end
                REQ_SETUP: begin
                    state <= REQ_ACCESS;
                end
                REQ_ACCESS: begin
                    if (pready) begin
                        state  <= REQ_IDLE;
                        done   <= 1'b1;
                        rdata  <= prdata;
                        slverr <= pslverr;
                    end
                end
                default: state <= REQ_IDLE;
            endcase
        end
    end

    // Request fields stay stable for the whole transfer.
    always_ff @(posedge clock) begin
        if (accept) begin
            paddr  <= cmd_addr;
            pwrite <= (cmd_op == OP_WRITE);
            pwdata <= cmd_wdata;
            pstrb  <= cmd_strb;
            pprot  <= cmd_prot;
        end
    end

endmodule

`default_nettype wire

//--- hdl/apb_wait_memory.sv
`timescale 1ns/1ns
`default_nettype none
`include "apb_delay_params.svh"

module apb_wait_memory import apb_delay_pkg::*; (
    input  wire                     clock,
    input  wire                     reset,
    input  wire  [`APB_ADDR_W-1:0]  paddr,
    input  wire                     psel,
    input  wire                     penable,
    input  wire  [`APB_PROT_W-1:0]  pprot,
    input  wire                     pwrite,
    input  wire  [`APB_DATA_W-1:0]  pwdata,
    input  wire  [`APB_STRB_W-1:0]  pstrb,
    output logic                    pready,
    output logic [`APB_DATA_W-1:0]  prdata,
    output logic                    pslverr
);

    localparam int IDX_W     = `APB_ADDR_W - 2;
    localparam int MEM_IDX_W = $clog2(`MEM_WORDS);
    localparam int WAIT_W    = $clog2(`MAX_WAIT + 1);

    logic [`APB_DATA_W-1:0] mem [`MEM_WORDS];
    mem_state_t             state;
    logic [WAIT_W-1:0]      wait_cnt;
    logic [WAIT_W-1:0]      wait_need;
    logic [IDX_W-1:0]       word_idx;
    logic [MEM_IDX_W-1:0]   mem_idx;
    logic                   access;
    logic                   fault;

    assign word_idx  = paddr[`APB_ADDR_W-1:2];
    assign mem_idx   = word_idx[MEM_IDX_W-1:0];
    assign wait_need = WAIT_W'(word_idx % (`MAX_WAIT + 1));  // Address-dependent wait.
    assign access    = psel && penable;
    assign fault     = (word_idx >= IDX_W'(`MEM_WORDS))
                    || (pprot[1] && (word_idx < IDX_W'(`PROT_WORDS)));  // Non-secure access.

    assign pready  = access && (wait_cnt == wait_need);
    assign pslverr = pready && fault;
    assign prdata  = (pready && !pwrite && !fault) ? mem[mem_idx] : '0;

    // ==============================
    // Wait-state counter
    // ==============================
    always_ff @(posedge clock) begin
        if (!reset) begin
            state    <= MEM_IDLE;
            wait_cnt <= '0;
        end else begin
            case (state)
                MEM_IDLE: begin
                    if (access && !pready) begin
                        state    <= MEM_WAIT;
                        wait_cnt <= WAIT_W'(1);
                    end
                end
                MEM_WAIT: begin
                    if (pready) begin
                        state    <= MEM_IDLE;
                        wait_cnt <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (pready && pwrite && !fault) begin
            for (int b = 0; b < `APB_STRB_W; b++) begin
                if (pstrb[b]) begin
                    mem[mem_idx][8*b +: 8] <= pwdata[8*b +: 8];  // Strobed bytes only.
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+hdl
hdl/apb_delay_pkg.sv
hdl/apb_requester.sv
hdl/apb_delayer.sv
hdl/apb_wait_memory.sv
hdl/apb_delay_top.sv
dv/apb_delay_tb.sv
